//--- tb.f
+incdir+include
src/ddrc_pkg.sv
src/ddrc_ram.sv
src/ddrc_cmd_sequencer.sv
src/ddrc_cmd_decode.sv
src/ddrc_chan_buffers.sv
src/ddrc_top.sv
test/tb_clk_gen.sv
test/tb_ddrc.sv

//--- Bender.yml
package:
  name: ddrc_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/ddrc_pkg.sv
      - src/ddrc_ram.sv
      - src/ddrc_cmd_sequencer.sv
      - src/ddrc_cmd_decode.sv
      - src/ddrc_chan_buffers.sv
      - src/ddrc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clk_gen.sv
      - test/tb_ddrc.sv

//--- test/tb_ddrc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DDR3 sequencing core testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "ddrc_consts.svh"

module tb_ddrc;
    import ddrc_pkg::*;

    localparam int run_timeout   = 400; // cycles allowed per sequence
    localparam int reset_timeout = 50;

    logic                            mclk;
    logic                            rst;
    logic                            cmd_we;
    logic                            cmd_bank;
    cmd_addr_t                       cmd_waddr;
    cmd_word_t                       cmd_wdata;
    logic                            run_seq;
    cmd_addr_t                       run_addr;
    logic                            run_bank;
    chan_t                           run_chn;
    page_t                           rd_int_page;
    page_t                           wr_int_page;
    logic                            run_done;
    logic                            sd_ras;
    logic                            sd_cas;
    logic                            sd_we;
    logic [`DDRC_BA_BITS-1:0]        sd_ba;
    logic [`DDRC_ADDR_BITS-1:0]      sd_a;
    logic                            sd_cke;
    logic                            sd_odt;
    data_word_t                      sd_rdata;
    logic                            sd_rdata_take;
    data_word_t                      sd_wdata;
    logic                            sd_wdata_valid;
    logic                            rd_re;
    page_t                           rd_page;
    logic [`DDRC_PAGE_WORD_BITS-1:0] rd_addr;
    data_word_t                      rd_data;
    logic                            wr_we;
    page_t                           wr_page;
    logic [`DDRC_PAGE_WORD_BITS-1:0] wr_addr;
    data_word_t                      wr_data;

    integer     seed = 15616;
    logic       rdata_drive;        // memory model sends data
    cmd_word_t  exp_cmds[$];        // expected bus commands, in order
    int         cmd_cycles[$];      // cycle of each bus command
    data_word_t wdata_seen[$];      // sd_wdata while valid
    data_word_t rdata_seen[$];      // sd_rdata while taken
    data_word_t wr_model [0:3][0:7]; // write channel contents

    tb_clk_gen u_clk_gen (.mclk(mclk), .rst(rst));

    ddrc_top u_dut (.*);

    // memory side read data changes every clock
    always @(posedge mclk) begin
        if (rdata_drive) begin
            sd_rdata <= {$random(seed), $random(seed)};
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // only fields visible on the pins take part
    task automatic check_cmd_word(input string name, input cmd_word_t got, input cmd_word_t exp);
        cmd_word_t mask;
        mask = '0;
        mask[`DDRC_F_BUF_WR:0] = '1;
        if ((got & mask) !== (exp & mask)) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name,
                               got & mask, exp & mask));
        end
    endtask

    task automatic check_data(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic cmd_word_t make_cmd(input ddr_cmd_t kind, input logic [2:0] ba,
                                           input logic [14:0] a, input logic cke,
                                           input logic odt, input logic bwr, input logic brd);
        cmd_word_t w;
        w = '0;
        w[`DDRC_ADDR_BITS-1:0]              = a;
        w[`DDRC_ADDR_BITS +: `DDRC_BA_BITS] = ba;
        {w[`DDRC_F_RAS], w[`DDRC_F_CAS], w[`DDRC_F_WE]} = kind; // positive logic
        w[`DDRC_F_CKE]    = cke;
        w[`DDRC_F_ODT]    = odt;
        w[`DDRC_F_BUF_WR] = bwr;
        w[`DDRC_F_BUF_RD] = brd;
        return w;
    endfunction

    function automatic cmd_word_t make_nop(input pause_t pause, input logic done);
        cmd_word_t w;
        w = '0;
        w[`DDRC_PAUSE_BITS-1:0] = pause;
        w[`DDRC_DONE_BIT]       = done;
        return w;
    endfunction

    // rebuild a word from the pins
    function automatic cmd_word_t bus_snapshot();
        cmd_word_t w;
        w = '0;
        w[`DDRC_ADDR_BITS-1:0]              = sd_a;
        w[`DDRC_ADDR_BITS +: `DDRC_BA_BITS] = sd_ba;
        w[`DDRC_F_RAS]    = sd_ras;
        w[`DDRC_F_CAS]    = sd_cas;
        w[`DDRC_F_WE]     = sd_we;
        w[`DDRC_F_ODT]    = sd_odt;
        w[`DDRC_F_CKE]    = sd_cke;
        w[`DDRC_F_BUF_WR] = sd_rdata_take; // buf_wr shows up as the take strobe
        return w;
    endfunction

    task automatic load_cmd(input logic bank, input cmd_addr_t addr, input cmd_word_t word);
        @(posedge mclk);
        cmd_we    <= 1'b1;
        cmd_bank  <= bank;
        cmd_waddr <= addr;
        cmd_wdata <= word;
        @(posedge mclk);
        cmd_we    <= 1'b0;
    endtask

    task automatic load_wr_word(input page_t page, input int idx, input data_word_t data);
        @(posedge mclk);
        wr_we   <= 1'b1;
        wr_page <= page;
        wr_addr <= idx[`DDRC_PAGE_WORD_BITS-1:0];
        wr_data <= data;
        @(posedge mclk);
        wr_we   <= 1'b0;
    endtask

    task automatic read_back(input page_t page, input int idx, output data_word_t data);
        @(posedge mclk);
        rd_re   <= 1'b1;
        rd_page <= page;
        rd_addr <= idx[`DDRC_PAGE_WORD_BITS-1:0];
        @(posedge mclk);
        rd_re   <= 1'b0;
        @(negedge mclk);
        data = rd_data; // one cycle after rd_re
    endtask

    // start a run and watch the pins until a few cycles past run_done
    task automatic run_sequence(input logic bank, input cmd_addr_t addr, input chan_t chn,
                                input page_t rpage, input page_t wpage);
        int cycle;
        int n_cmd;
        int n_done;
        int tail;
        cmd_addr_t start_addr;
        cmd_cycles.delete();
        wdata_seen.delete();
        rdata_seen.delete();
        cycle = 0;
        n_cmd = 0;
        n_done = 0;
        tail = 0;
        start_addr = addr;
        @(posedge mclk);
        run_seq     <= 1'b1;
        run_addr    <= start_addr;
        run_bank    <= bank;
        run_chn     <= chn;
        rd_int_page <= rpage;
        wr_int_page <= wpage;
        @(posedge mclk);
        run_seq     <= 1'b0;
        while (tail < 4) begin
            @(negedge mclk);
            cycle++;
            if (cycle > run_timeout) begin
                fail_run("timeout waiting for run_done");
            end
            if (run_done) begin
                n_done++;
                if (n_done > 1) begin
                    fail_run("run_done was high for more than one cycle");
                end
                if (n_cmd != exp_cmds.size()) begin
                    fail_run("run_done came before the last command");
                end
            end
            if (sd_ras || sd_cas || sd_we) begin
                if (n_done != 0) begin
                    fail_run("command on the bus after run_done");
                end
                if (n_cmd >= exp_cmds.size()) begin
                    fail_run("more commands on the bus than the sequence holds");
                end
                check_cmd_word("bus command", bus_snapshot(), exp_cmds[n_cmd]);
                cmd_cycles.push_back(cycle);
                n_cmd++;
            end
            if (sd_wdata_valid) begin
                wdata_seen.push_back(sd_wdata);
            end
            if (sd_rdata_take) begin
                rdata_seen.push_back(sd_rdata);
            end
            if (n_done != 0) begin
                tail++;
            end
        end
    endtask

    task automatic test_reset_state();
        int n;
        n = 0;
        @(negedge mclk);
        while (rst) begin
            @(negedge mclk);
            n++;
            if (n > reset_timeout) begin
                fail_run("reset was never released");
            end
        end
        @(negedge mclk);
        check_bit("sd_ras", sd_ras, 1'b0);
        check_bit("sd_cas", sd_cas, 1'b0);
        check_bit("sd_we", sd_we, 1'b0);
        check_bit("sd_cke", sd_cke, 1'b0);
        check_bit("sd_odt", sd_odt, 1'b0);
        check_bit("run_done", run_done, 1'b0);
        check_bit("sd_wdata_valid", sd_wdata_valid, 1'b0);
        check_bit("sd_rdata_take", sd_rdata_take, 1'b0);
    endtask

    task automatic test_bank0_seq();
        ddr_cmd_t        kinds [0:4];
        logic [2:0]      ba;
        logic [14:0]     a;
        cmd_word_t       w;
        kinds = '{CMD_MRS, CMD_PRE, CMD_REF, CMD_ACT, CMD_ZQC};
        exp_cmds.delete();
        for (int i = 0; i < 5; i++) begin
            ba = $random(seed);
            a  = $random(seed);
            w  = make_cmd(kinds[i], ba, a, 1'b1, i[0], 1'b0, 1'b0);
            exp_cmds.push_back(w);
            load_cmd(1'b0, cmd_addr_t'(10'h010 + i), w);
        end
        load_cmd(1'b0, 10'h015, make_nop('0, 1'b1)); // done
        run_sequence(1'b0, 10'h010, CHAN_RD, 2'd0, 2'd0);
    endtask

    task automatic test_pause_bank1();
        cmd_word_t first;
        cmd_word_t second;
        first  = make_cmd(CMD_ACT, 3'd2, 15'h1234, 1'b1, 1'b0, 1'b0, 1'b0);
        second = make_cmd(CMD_READ, 3'd2, 15'h0040, 1'b1, 1'b1, 1'b0, 1'b0);
        load_cmd(1'b1, 10'h020, first);
        load_cmd(1'b1, 10'h021, make_nop(pause_t'(20), 1'b0));
        load_cmd(1'b1, 10'h022, second);
        load_cmd(1'b1, 10'h023, make_nop('0, 1'b1));
        // decoys in the manual bank at the same addresses
        for (int i = 0; i < 4; i++) begin
            load_cmd(1'b0, cmd_addr_t'(10'h020 + i),
                     make_cmd(CMD_PRE, 3'd7, 15'(15'h7f00 + i), 1'b0, 1'b1, 1'b0, 1'b0));
        end
        exp_cmds.delete();
        exp_cmds.push_back(first);
        exp_cmds.push_back(second);
        run_sequence(1'b1, 10'h020, CHAN_RD, 2'd0, 2'd0);
        if (cmd_cycles[1] - cmd_cycles[0] - 1 < 20) begin
            fail_run("second command came less than 20 idle cycles after the pause");
        end
    endtask

    task automatic test_write_chan();
        data_word_t d;
        cmd_word_t  w;
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < 8; i++) begin
                d = {$random(seed), $random(seed)};
                wr_model[p][i] = d;
                load_wr_word(page_t'(p), i, d);
            end
        end
        exp_cmds.delete();
        for (int i = 0; i < 8; i++) begin
            w = make_cmd(CMD_WRITE, 3'd1, 15'(i * 8), 1'b1, 1'b1, 1'b0, 1'b1);
            exp_cmds.push_back(w);
            load_cmd(1'b1, cmd_addr_t'(10'h100 + i), w);
        end
        load_cmd(1'b1, 10'h108, make_nop('0, 1'b1));
        run_sequence(1'b1, 10'h100, CHAN_WR, 2'd0, 2'd2);
        if (wdata_seen.size() != 8) begin
            fail_run("sd_wdata_valid did not pulse once per buf_rd command");
        end
        for (int i = 0; i < 8; i++) begin
            check_data("sd_wdata", wdata_seen[i], wr_model[2][i]);
        end
    endtask

    task automatic test_read_chan();
        data_word_t d;
        cmd_word_t  w;
        exp_cmds.delete();
        for (int i = 0; i < 6; i++) begin
            w = make_cmd(CMD_READ, 3'd5, 15'(i * 8), 1'b1, 1'b0, 1'b1, 1'b0);
            exp_cmds.push_back(w);
            load_cmd(1'b0, cmd_addr_t'(10'h200 + i), w);
        end
        load_cmd(1'b0, 10'h206, make_nop('0, 1'b1));
        @(posedge mclk);
        rdata_drive <= 1'b1;
        run_sequence(1'b0, 10'h200, CHAN_RD, 2'd1, 2'd3);
        @(posedge mclk);
        rdata_drive <= 1'b0;
        if (rdata_seen.size() != 6) begin
            fail_run("sd_rdata_take did not pulse once per buf_wr command");
        end
        for (int i = 0; i < 6; i++) begin
            read_back(2'd1, i, d);
            check_data("rd_data", d, rdata_seen[i]);
        end
    endtask

    initial begin
        cmd_we      = 1'b0;
        cmd_bank    = 1'b0;
        cmd_waddr   = '0;
        cmd_wdata   = '0;
        run_seq     = 1'b0;
        run_addr    = '0;
        run_bank    = 1'b0;
        run_chn     = CHAN_RD;
        rd_int_page = '0;
        wr_int_page = '0;
        sd_rdata    = '0;
        rd_re       = 1'b0;
        rd_page     = '0;
        rd_addr     = '0;
        wr_we       = 1'b0;
        wr_page     = '0;
        wr_addr     = '0;
        wr_data     = '0;
        rdata_drive = 1'b0;
        test_reset_state();
        test_bank0_seq();
        test_pause_bank1();
        test_write_chan();
        test_read_chan();
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- test/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int period_ns  = 100, // mclk period
    parameter int rst_cycles = 10   // reset length in clocks
) (
    output logic mclk,
    output logic rst
);

    initial begin
        mclk = 1'b0;
        forever #(period_ns / 2) mclk = ~mclk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge mclk);
        rst <= 1'b0; // release on an edge, like a synced reset
    end

endmodule

//--- src/ddrc_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DDR3 controller sequencing core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "ddrc_consts.svh"

module ddrc_top (
    input  logic                            mclk,
    input  logic                            rst,
    input  logic                            cmd_we,
    input  logic                            cmd_bank,
    input  ddrc_pkg::cmd_addr_t             cmd_waddr,
    input  ddrc_pkg::cmd_word_t             cmd_wdata,
    input  logic                            run_seq,
    input  ddrc_pkg::cmd_addr_t             run_addr,
    input  logic                            run_bank,
    input  ddrc_pkg::chan_t                 run_chn,
    input  ddrc_pkg::page_t                 rd_int_page,
    input  ddrc_pkg::page_t                 wr_int_page,
    output logic                            run_done,
    output logic                            sd_ras,
    output logic                            sd_cas,
    output logic                            sd_we,
    output logic [`DDRC_BA_BITS-1:0]        sd_ba,
    output logic [`DDRC_ADDR_BITS-1:0]      sd_a,
    output logic                            sd_cke,
    output logic                            sd_odt,
    input  ddrc_pkg::data_word_t            sd_rdata,
    output logic                            sd_rdata_take,
    output ddrc_pkg::data_word_t            sd_wdata,
    output logic                            sd_wdata_valid,
    input  logic                            rd_re,
    input  ddrc_pkg::page_t                 rd_page,
    input  logic [`DDRC_PAGE_WORD_BITS-1:0] rd_addr,
    output ddrc_pkg::data_word_t            rd_data,
    input  logic                            wr_we,
    input  ddrc_pkg::page_t                 wr_page,
    input  logic [`DDRC_PAGE_WORD_BITS-1:0] wr_addr,
    input  ddrc_pkg::data_word_t            wr_data
);
    import ddrc_pkg::*;

    cmd_word_t cmd_word;  // fetched word
    logic      cmd_valid;
    logic      cmd_nop;
    pause_t    pause_len;
    logic      seq_end;
    logic      seq_start; // accepted run, one cycle late
    logic      buf_wr;
    logic      buf_rd;

    ddrc_cmd_sequencer u_sequencer (
        .mclk      (mclk),
        .rst       (rst),
        .cmd_we    (cmd_we),
        .cmd_bank  (cmd_bank),
        .cmd_waddr (cmd_waddr),
        .cmd_wdata (cmd_wdata),
        .run_seq   (run_seq),
        .run_addr  (run_addr),
        .run_bank  (run_bank),
        .cmd_nop   (cmd_nop),
        .pause_len (pause_len),
        .seq_end   (seq_end),
        .cmd_word  (cmd_word),
        .cmd_valid (cmd_valid),
        .seq_start (seq_start),
        .run_done  (run_done)
    );

    ddrc_cmd_decode u_decode (
        .mclk      (mclk),
        .rst       (rst),
        .cmd_word  (cmd_word),
        .cmd_valid (cmd_valid),
        .cmd_nop   (cmd_nop),
        .pause_len (pause_len),
        .seq_end   (seq_end),
        .sd_ras    (sd_ras),
        .sd_cas    (sd_cas),
        .sd_we     (sd_we),
        .sd_ba     (sd_ba),
        .sd_a      (sd_a),
        .sd_cke    (sd_cke),
        .sd_odt    (sd_odt),
        .buf_wr    (buf_wr),
        .buf_rd    (buf_rd)
    );

    ddrc_chan_buffers u_buffers (
        .mclk           (mclk),
        .rst            (rst),
        .run_seq        (run_seq),
        .run_chn        (run_chn),
        .rd_int_page    (rd_int_page),
        .wr_int_page    (wr_int_page),
        .seq_start      (seq_start),
        .buf_wr         (buf_wr),
        .buf_rd         (buf_rd),
        .sd_rdata       (sd_rdata),
        .rd_re          (rd_re),
        .rd_page        (rd_page),
        .rd_addr        (rd_addr),
        .wr_we          (wr_we),
        .wr_page        (wr_page),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .sd_wdata       (sd_wdata),
        .sd_wdata_valid (sd_wdata_valid),
        .sd_rdata_take  (sd_rdata_take),
        .rd_data        (rd_data)
    );

endmodule

//--- src/ddrc_chan_buffers.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Paged channel buffers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "ddrc_consts.svh"

module ddrc_chan_buffers (
    input  logic                            mclk,
    input  logic                            rst,
    input  logic                            run_seq,
    input  ddrc_pkg::chan_t                 run_chn,
    input  ddrc_pkg::page_t                 rd_int_page,    // read channel start page
    input  ddrc_pkg::page_t                 wr_int_page,    // write channel start page
    input  logic                            seq_start,
    input  logic                            buf_wr,
    input  logic                            buf_rd,
    input  ddrc_pkg::data_word_t            sd_rdata,       // data from memory
    input  logic                            rd_re,          // host read port
    input  ddrc_pkg::page_t                 rd_page,
    input  logic [`DDRC_PAGE_WORD_BITS-1:0] rd_addr,
    input  logic                            wr_we,          // host write port
    input  ddrc_pkg::page_t                 wr_page,
    input  logic [`DDRC_PAGE_WORD_BITS-1:0] wr_addr,
    input  ddrc_pkg::data_word_t            wr_data,
    output ddrc_pkg::data_word_t            sd_wdata,       // data to memory
    output logic                            sd_wdata_valid,
    output logic                            sd_rdata_take,
    output ddrc_pkg::data_word_t            rd_data
);
    import ddrc_pkg::*;

    chan_t     chn_r;    // channel of the current run
    page_t     page_r;   // its start page
    buf_addr_t buf_addr; // burst address, memory side
    logic      rd_take;  // read channel capture
    logic      wr_send;  // write channel fetch

    assign rd_take = buf_wr && (chn_r == CHAN_RD);
    assign wr_send = buf_rd && (chn_r == CHAN_WR);

    assign sd_rdata_take = rd_take; // sampled on this edge

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            chn_r          <= CHAN_RD;
            page_r         <= '0;
            buf_addr       <= '0;
            sd_wdata_valid <= 1'b0;
        end else begin
            if (run_seq) begin
                chn_r  <= run_chn;
                page_r <= (run_chn == CHAN_RD) ? rd_int_page : wr_int_page;
            end
            if (seq_start) begin
                buf_addr <= {page_r, {`DDRC_PAGE_WORD_BITS{1'b0}}}; // word 0 of page
            end else if (rd_take || wr_send) begin
                buf_addr <= buf_addr + 1'b1;
            end
            sd_wdata_valid <= wr_send; // RAM read takes one cycle
        end
    end

    // read channel: memory writes, host reads
    ddrc_ram #(
        .word_t    (data_word_t),
        .addr_bits ($bits(buf_addr_t))
    ) u_rd_chan_ram (
        .mclk  (mclk),
        .we    (rd_take),
        .waddr (buf_addr),
        .wdata (sd_rdata),
        .re    (rd_re),
        .raddr ({rd_page, rd_addr}),
        .rdata (rd_data)
    );

    // write channel: host writes, memory reads
    ddrc_ram #(
        .word_t    (data_word_t),
        .addr_bits ($bits(buf_addr_t))
    ) u_wr_chan_ram (
        .mclk  (mclk),
        .we    (wr_we),
        .waddr ({wr_page, wr_addr}),
        .wdata (wr_data),
        .re    (wr_send),
        .raddr (buf_addr),
        .rdata (sd_wdata)
    );

endmodule

//--- src/ddrc_cmd_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command word decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "ddrc_consts.svh"

module ddrc_cmd_decode (
    input  logic                       mclk,
    input  logic                       rst,
    input  ddrc_pkg::cmd_word_t        cmd_word,
    input  logic                       cmd_valid,
    output logic                       cmd_nop,   // ras, cas, we all low
    output ddrc_pkg::pause_t           pause_len,
    output logic                       seq_end,
    output logic                       sd_ras,
    output logic                       sd_cas,
    output logic                       sd_we,
    output logic [`DDRC_BA_BITS-1:0]   sd_ba,
    output logic [`DDRC_ADDR_BITS-1:0] sd_a,
    output logic                       sd_cke,
    output logic                       sd_odt,
    output logic                       buf_wr,    // take memory data
    output logic                       buf_rd     // send buffer data
);
    import ddrc_pkg::*;

    ddr_cmd_t cmd_kind; // kind of the current word
    ddr_cmd_t bus_kind; // kind on the pins

    assign cmd_kind  = ddr_cmd_t'({cmd_word[`DDRC_F_RAS],
                                   cmd_word[`DDRC_F_CAS],
                                   cmd_word[`DDRC_F_WE]});
    assign cmd_nop   = (cmd_kind == CMD_NOP);
    assign pause_len = cmd_word[`DDRC_PAUSE_BITS-1:0];   // NOP only
    assign seq_end   = cmd_nop && cmd_word[`DDRC_DONE_BIT];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            bus_kind <= CMD_NOP;
            sd_cke   <= 1'b0;
            sd_odt   <= 1'b0;
            buf_wr   <= 1'b0;
            buf_rd   <= 1'b0;
        end else begin
            bus_kind <= cmd_valid ? cmd_kind : CMD_NOP; // idle pins between words
            buf_wr   <= cmd_valid && cmd_word[`DDRC_F_BUF_WR];
            buf_rd   <= cmd_valid && cmd_word[`DDRC_F_BUF_RD];
            if (cmd_valid) begin
                sd_cke <= cmd_word[`DDRC_F_CKE]; // level, kept between words
                sd_odt <= cmd_word[`DDRC_F_ODT];
            end
        end
    end

    // address and bank follow the last valid word
    always_ff @(posedge mclk) begin
        if (cmd_valid) begin
            sd_a  <= cmd_word[`DDRC_ADDR_BITS-1:0];
            sd_ba <= cmd_word[`DDRC_ADDR_BITS +: `DDRC_BA_BITS];
        end
    end

    assign {sd_ras, sd_cas, sd_we} = bus_kind;

endmodule

//--- src/ddrc_cmd_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command memories and fetch sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "ddrc_consts.svh"

module ddrc_cmd_sequencer (
    input  logic                mclk,
    input  logic                rst,
    input  logic                cmd_we,    // host write strobe
    input  logic                cmd_bank,  // 0 manual, 1 auto
    input  ddrc_pkg::cmd_addr_t cmd_waddr,
    input  ddrc_pkg::cmd_word_t cmd_wdata,
    input  logic                run_seq,   // start strobe
    input  ddrc_pkg::cmd_addr_t run_addr,
    input  logic                run_bank,
    input  logic                cmd_nop,   // from decoder
    input  ddrc_pkg::pause_t    pause_len, // from decoder
    input  logic                seq_end,   // from decoder
    output ddrc_pkg::cmd_word_t cmd_word,
    output logic                cmd_valid,
    output logic                seq_start,
    output logic                run_done
);
    import ddrc_pkg::*;

    logic [1:0] busy;       // bit 0 active, bit 1 delayed copy
    logic       bank_sel;   // bank of the running sequence
    cmd_addr_t  cmd_addr;   // fetch address
    pause_t     pause_cntr;
    logic       run_ok;
    logic       nop_valid;
    logic       end_valid;
    logic       pause;
    logic       fetch;
    cmd_word_t  cmd0_rdata; // manual bank output
    cmd_word_t  cmd1_rdata; // auto bank output

    assign run_ok    = run_seq && !busy[0]; // ignored while busy
    assign nop_valid = cmd_valid && cmd_nop;
    assign end_valid = cmd_valid && seq_end;

    // stop at once on a pausing NOP, then until the counter runs down
    assign pause = (nop_valid && (pause_len != '0)) || (pause_cntr > pause_t'(1));
    assign fetch = busy[0] && !pause && !end_valid;

    assign seq_start = busy[0] && !busy[1]; // first active cycle
    assign cmd_word  = bank_sel ? cmd1_rdata : cmd0_rdata;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy       <= '0;
            bank_sel   <= 1'b0;
            cmd_addr   <= '0;
            pause_cntr <= '0;
            cmd_valid  <= 1'b0;
            run_done   <= 1'b0;
        end else begin
            if (end_valid) begin
                busy <= '0;
            end else begin
                busy <= {busy[0], busy[0] | run_ok};
            end
            if (run_ok) begin
                bank_sel <= run_bank;
                cmd_addr <= run_addr;
            end else if (fetch) begin
                cmd_addr <= cmd_addr + 1'b1; // next word while this one is read
            end
            if (!busy[0]) begin
                pause_cntr <= '0;
            end else if (nop_valid) begin
                pause_cntr <= pause_len;
            end else if (pause_cntr != '0) begin
                pause_cntr <= pause_cntr - 1'b1;
            end
            cmd_valid <= fetch;     // word out of RAM next cycle
            run_done  <= end_valid; // single pulse
        end
    end

    ddrc_ram #(
        .word_t    (cmd_word_t),
        .addr_bits (`DDRC_CMD_DEPTH_LOG)
    ) u_cmd0_ram (
        .mclk  (mclk),
        .we    (cmd_we && !cmd_bank),
        .waddr (cmd_waddr),
        .wdata (cmd_wdata),
        .re    (fetch && !bank_sel),
        .raddr (cmd_addr),
        .rdata (cmd0_rdata)
    );

    ddrc_ram #(
        .word_t    (cmd_word_t),
        .addr_bits (`DDRC_CMD_DEPTH_LOG)
    ) u_cmd1_ram (
        .mclk  (mclk),
        .we    (cmd_we && cmd_bank),
        .waddr (cmd_waddr),
        .wdata (cmd_wdata),
        .re    (fetch && bank_sel),
        .raddr (cmd_addr),
        .rdata (cmd1_rdata)
    );

endmodule

//--- src/ddrc_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-port RAM, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ddrc_ram #(
    parameter type word_t    = logic [31:0], // stored payload
    parameter int  addr_bits = 10            // log2 of depth
) (
    input  logic                 mclk,
    input  logic                 we,
    input  logic [addr_bits-1:0] waddr,
    input  word_t                wdata,
    input  logic                 re,
    input  logic [addr_bits-1:0] raddr,
    output word_t                rdata
);

    word_t mem [0:(1<<addr_bits)-1]; // storage, maps to block RAM

    // write port
    always_ff @(posedge mclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, output register loads only on re
    always_ff @(posedge mclk) begin
        if (re) begin
            rdata <= mem[raddr]; // holds last word otherwise
        end
    end

endmodule

//--- src/ddrc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DDR3 sequencer shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ddrc_consts.svh"

package ddrc_pkg;

    typedef logic [`DDRC_CMD_WORD_BITS-1:0] cmd_word_t;  // one sequencer word
    typedef logic [`DDRC_CMD_DEPTH_LOG-1:0] cmd_addr_t;  // address within a bank
    typedef logic [`DDRC_DATA_BITS-1:0]     data_word_t; // burst data word
    typedef logic [`DDRC_PAGE_BITS-1:0]     page_t;      // page within a channel
    typedef logic [`DDRC_PAUSE_BITS-1:0]    pause_t;     // NOP pause length

    // page number on top, word index below
    typedef logic [`DDRC_PAGE_BITS+`DDRC_PAGE_WORD_BITS-1:0] buf_addr_t;

    typedef logic chan_t; // data channel select

    localparam chan_t CHAN_RD = 1'b0; // memory to host
    localparam chan_t CHAN_WR = 1'b1; // host to memory

    // command kind, packed as {ras, cas, we} in positive logic
    typedef enum logic [2:0] {
        CMD_NOP   = 3'b000,
        CMD_ZQC   = 3'b001, // ZQ calibration
        CMD_READ  = 3'b010,
        CMD_WRITE = 3'b011,
        CMD_ACT   = 3'b100, // row activate
        CMD_PRE   = 3'b101, // precharge
        CMD_REF   = 3'b110, // refresh
        CMD_MRS   = 3'b111  // mode register set
    } ddr_cmd_t;

endpackage

//--- include/ddrc_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DDR3 sequencer constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DDRC_CONSTS_SVH
`define DDRC_CONSTS_SVH

// memory side widths
`define DDRC_ADDR_BITS      15 // row/column address, 4Gb part
`define DDRC_BA_BITS        3  // bank address

// command memories
`define DDRC_CMD_DEPTH_LOG  10 // 1k words per bank
`define DDRC_CMD_WORD_BITS  32

// channel buffers
`define DDRC_DATA_BITS      64 // one burst word
`define DDRC_PAGE_BITS      2  // 4 pages per channel
`define DDRC_PAGE_WORD_BITS 7  // 128 words per page

// NOP word fields, taken from the address bits
`define DDRC_PAUSE_BITS     6  // pause length, low address bits
`define DDRC_DONE_BIT       6  // end of sequence

// flag positions in the command word, above address and bank
`define DDRC_F_RAS          18
`define DDRC_F_CAS          19
`define DDRC_F_WE           20
`define DDRC_F_ODT          21
`define DDRC_F_CKE          22
`define DDRC_F_BUF_WR       23 // memory data into read channel
`define DDRC_F_BUF_RD       24 // write channel data to memory

`endif
